//--- frame_rev.f
+incdir+include
hdl/frame_rev_pkg.sv
hdl/ram_async_dualport.sv
hdl/frame_addr_counter.sv
hdl/frame_rev_ctrl.sv
hdl/frame_rev_top.sv
verif/frame_rev_tb.sv

//--- hdl/frame_addr_counter.sv
`default_nettype none

`include "frame_rev_defines.svh"

module frame_addr_counter (
    input  var logic                 port0_clk,
    input  var logic                 rst_n,
    input  var logic                 clear,
    input  var logic                 up,
    input  var logic                 down,
    output frame_rev_pkg::len_t      count,
    output frame_rev_pkg::addr_t     wr_addr,
    output frame_rev_pkg::addr_t     rd_addr,
    output logic                     full,
    output logic                     zero
);

    frame_rev_pkg::len_t rd_count;

    // ----------------------------------------
    // word count register
    // ----------------------------------------

    // saturates at both ends
    always_ff @(posedge port0_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (up && !full) begin
            count <= count + frame_rev_pkg::len_t'(1);
        end else if (down && !zero) begin
            count <= count - frame_rev_pkg::len_t'(1);
        end
    end

    // ----------------------------------------
    // flags and addresses
    // ----------------------------------------

    assign full = (count == frame_rev_pkg::len_t'(`FRAME_REV_DEPTH));
    assign zero = (count == '0);

    // next free slot
    assign wr_addr = count[`FRAME_REV_ADDR_WIDTH-1:0];

    // newest stored word, read back first
    assign rd_count = count - frame_rev_pkg::len_t'(1);
    assign rd_addr  = rd_count[`FRAME_REV_ADDR_WIDTH-1:0];

    // ----------------------------------------
    // command checks
    // ----------------------------------------

    a_up_down_excl: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        !(up && down)
    ) else $error("counter: up and down in the same cycle");

    a_no_up_when_full: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        full |-> !up
    ) else $error("counter: up while full");

    a_no_down_when_zero: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        zero |-> !down
    ) else $error("counter: down while zero");

endmodule

`default_nettype wire

//--- hdl/frame_rev_ctrl.sv
`default_nettype none

module frame_rev_ctrl (
    input  var logic                      port0_clk,
    input  var logic                      rst_n,
    input  var frame_rev_pkg::in_beat_t   in_beat,
    input  var frame_rev_pkg::len_t       count,
    input  var logic                      full,
    input  var logic                      zero,
    input  var frame_rev_pkg::data_t      rd_data,
    output logic                          clear,
    output logic                          up,
    output logic                          down,
    output logic                          we,
    output frame_rev_pkg::data_t          wr_data,
    output frame_rev_pkg::out_beat_t      out_beat,
    output logic                          busy,
    output logic                          overflow
);

    frame_rev_pkg::rev_state_e state;
    frame_rev_pkg::rev_state_e state_next;

    logic                 accept;
    logic                 keep;
    logic                 drop;
    logic                 last_read;
    logic                 ovf_seen;
    logic                 out_valid;
    logic                 out_last;
    frame_rev_pkg::data_t out_data;

    // ----------------------------------------
    // input side
    // ----------------------------------------

    // beats only count while filling
    assign accept = in_beat.valid
                    && (state == frame_rev_pkg::IDLE || state == frame_rev_pkg::FILL);
    assign keep   = accept && !full;
    assign drop   = accept && full;

    assign we      = keep;
    assign up      = keep;
    assign wr_data = in_beat.data;

    // ----------------------------------------
    // playback side
    // ----------------------------------------

    assign down      = (state == frame_rev_pkg::DRAIN) && !zero;
    assign clear     = (state == frame_rev_pkg::DONE);

    // address 0 is on the read port
    assign last_read = (count == frame_rev_pkg::len_t'(1));

    // next state
    always_comb begin
        state_next = state;
        case (state)
            frame_rev_pkg::IDLE, frame_rev_pkg::FILL: begin
                if (accept) begin
                    state_next = in_beat.last ? frame_rev_pkg::DRAIN : frame_rev_pkg::FILL;
                end
            end
            frame_rev_pkg::DRAIN: begin
                if (last_read || zero) begin
                    state_next = frame_rev_pkg::DONE;
                end
            end
            frame_rev_pkg::DONE: begin
                state_next = frame_rev_pkg::IDLE;
            end
            default: begin
                state_next = frame_rev_pkg::IDLE;
            end
        endcase
    end

    // control registers
    always_ff @(posedge port0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= frame_rev_pkg::IDLE;
            busy      <= 1'b0;
            ovf_seen  <= 1'b0;
            overflow  <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            state <= state_next;

            // busy from the last beat up to the end of DONE
            if (accept && in_beat.last) begin
                busy <= 1'b1;
            end else if (state == frame_rev_pkg::DONE) begin
                busy <= 1'b0;
            end

            // one overflow pulse per frame
            overflow <= drop && !ovf_seen;
            if (clear) begin
                ovf_seen <= 1'b0;
            end else if (drop) begin
                ovf_seen <= 1'b1;
            end

            out_valid <= down;
            out_last  <= down && last_read;
        end
    end

    // output word, captured while draining
    always_ff @(posedge port0_clk) begin
        if (down) begin
            out_data <= rd_data;
        end
    end

    assign out_beat = '{valid: out_valid, last: out_last, data: out_data};

    // ----------------------------------------
    // checks
    // ----------------------------------------

    a_no_out_while_filling: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        (state == frame_rev_pkg::IDLE || state == frame_rev_pkg::FILL) |-> !out_beat.valid
    ) else $error("ctrl: output beat outside playback");

    a_overflow_pulse: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        overflow |=> !overflow
    ) else $error("ctrl: overflow longer than one cycle");

    a_busy_state: assert property (
        @(posedge port0_clk) disable iff (!rst_n)
        busy == (state == frame_rev_pkg::DRAIN || state == frame_rev_pkg::DONE)
    ) else $error("ctrl: busy out of step with state");

endmodule

`default_nettype wire

//--- hdl/frame_rev_pkg.sv
`default_nettype none

`include "frame_rev_defines.svh"

package frame_rev_pkg;

    // ----------------------------------------
    // vector types
    // ----------------------------------------

    typedef logic [`FRAME_REV_DATA_WIDTH-1:0] data_t;
    typedef logic [`FRAME_REV_ADDR_WIDTH-1:0] addr_t;

    // 0 to DEPTH words, so one bit more than an address
    typedef logic [`FRAME_REV_ADDR_WIDTH:0] len_t;

    // ----------------------------------------
    // stream beats
    // ----------------------------------------

    typedef struct packed {
        logic  valid;
        logic  last;
        data_t data;
    } in_beat_t;

    typedef struct packed {
        logic  valid;
        logic  last;
        data_t data;
    } out_beat_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        DRAIN,
        DONE
    } rev_state_e;

endpackage

`default_nettype wire

//--- hdl/frame_rev_top.sv
`default_nettype none

`include "frame_rev_defines.svh"

module frame_rev_top (
    input  var logic                     port0_clk,
    input  var logic                     rst_n,
    input  var frame_rev_pkg::in_beat_t  in_beat,
    output frame_rev_pkg::out_beat_t     out_beat,
    output logic                         busy,
    output logic                         overflow
);

    // counter commands and status
    logic                 clear;
    logic                 up;
    logic                 down;
    logic                 full;
    logic                 zero;
    frame_rev_pkg::len_t  count;
    frame_rev_pkg::addr_t wr_addr;
    frame_rev_pkg::addr_t rd_addr;

    // RAM data
    logic                 we;
    frame_rev_pkg::data_t wr_data;
    frame_rev_pkg::data_t rd_data;

    frame_rev_ctrl u_ctrl (
        .port0_clk (port0_clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .count     (count),
        .full      (full),
        .zero      (zero),
        .rd_data   (rd_data),
        .clear     (clear),
        .up        (up),
        .down      (down),
        .we        (we),
        .wr_data   (wr_data),
        .out_beat  (out_beat),
        .busy      (busy),
        .overflow  (overflow)
    );

    frame_addr_counter u_count (
        .port0_clk (port0_clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .up        (up),
        .down      (down),
        .count     (count),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .full      (full),
        .zero      (zero)
    );

    // port0 readback is not needed here
    ram_async_dualport #(
        .ADDR_WIDTH (`FRAME_REV_ADDR_WIDTH),
        .DATA_WIDTH (`FRAME_REV_DATA_WIDTH)
    ) u_ram (
        .port0_clk  (port0_clk),
        .port0_we   (we),
        .port0_addr (wr_addr),
        .port0_din  (wr_data),
        .port0_dout (),
        .port1_addr (rd_addr),
        .port1_dout (rd_data)
    );

endmodule

`default_nettype wire

//--- hdl/ram_async_dualport.sv
`default_nettype none

module ram_async_dualport #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16
) (
    // port0, write and read
    input  var logic                  port0_clk,
    input  var logic                  port0_we,
    input  var logic [ADDR_WIDTH-1:0] port0_addr,
    input  var logic [DATA_WIDTH-1:0] port0_din,
    output logic     [DATA_WIDTH-1:0] port0_dout,

    // port1, read only
    input  var logic [ADDR_WIDTH-1:0] port1_addr,
    output logic     [DATA_WIDTH-1:0] port1_dout
);

    localparam int MEM_SIZE = 1 << ADDR_WIDTH;

    // ----------------------------------------
    // storage array
    // ----------------------------------------

    logic [DATA_WIDTH-1:0] mem [0:MEM_SIZE-1];

    // write on the clock edge
    always_ff @(posedge port0_clk) begin
        if (port0_we) begin
            mem[port0_addr] <= port0_din;
        end
    end

    // ----------------------------------------
    // combinational reads
    // ----------------------------------------

    // port0 sees the old word in the write cycle
    assign port0_dout = mem[port0_addr];

    assign port1_dout = mem[port1_addr];

endmodule

`default_nettype wire

//--- include/frame_rev_defines.svh
`ifndef FRAME_REV_DEFINES_SVH
`define FRAME_REV_DEFINES_SVH

// width of one stream word
`define FRAME_REV_DATA_WIDTH 16

// RAM address width
`define FRAME_REV_ADDR_WIDTH 6

// RAM word count, 2**ADDR_WIDTH
`define FRAME_REV_DEPTH 64

`endif

//--- verif/frame_rev_tb.sv
`default_nettype none

`include "frame_rev_defines.svh"

module frame_rev_tb;

    localparam int NUM_FRAMES = 16;
    localparam int JUNK_BEATS = 6;

    logic                     port0_clk;
    logic                     rst_n;
    frame_rev_pkg::in_beat_t  in_beat;
    frame_rev_pkg::out_beat_t out_beat;
    logic                     busy;
    logic                     overflow;

    // reference model state
    frame_rev_pkg::data_t kept[$];
    frame_rev_pkg::data_t exp_data;
    logic                 exp_last;
    logic                 exp_present;
    logic                 ovf_expect;

    logic [31:0] lcg_state;
    int          frame_len [NUM_FRAMES];
    int          watch_cycles;
    int          errors;
    int          errors_at_start;
    int          passed;
    int          failed;

    frame_rev_top i_dut (
        .port0_clk (port0_clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .out_beat  (out_beat),
        .busy      (busy),
        .overflow  (overflow)
    );

    initial port0_clk = 1'b0;
    always #2 port0_clk = ~port0_clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic log_mismatch(string sig, logic [31:0] expected, logic [31:0] actual);
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, sig, expected, actual);
        errors++;
    endtask

    task automatic log_problem(string msg);
        $display("time=%0t %s", $time, msg);
        errors++;
    endtask

    // one frame, words pushed to the model as they are driven
    task automatic send_frame(int len);
        frame_rev_pkg::data_t word;
        for (int i = 0; i < len; i++) begin
            @(negedge port0_clk);
            word    = frame_rev_pkg::data_t'(lcg_next() >> 16);
            in_beat = '{valid: 1'b1, last: (i == len - 1), data: word};
            if (i < `FRAME_REV_DEPTH) begin
                kept.push_back(word);
            end
            ovf_expect = (i == `FRAME_REV_DEPTH);
        end
        @(negedge port0_clk);
        in_beat    = '0;
        ovf_expect = 1'b0;
    endtask

    // beats presented while busy, never stored
    task automatic send_ignored(int count);
        for (int i = 0; i < count; i++) begin
            @(negedge port0_clk);
            if (!busy) begin
                log_problem("busy dropped before the ignored beats were sent");
                break;
            end
            in_beat = '{valid: 1'b1, last: i[0], data: frame_rev_pkg::data_t'(lcg_next())};
        end
        @(negedge port0_clk);
        in_beat = '0;
    endtask

    // returns at the falling edge inside the out_last cycle
    task automatic wait_playback(int len);
        int cycles;
        cycles = 0;
        do begin
            @(negedge port0_clk);
            cycles++;
        end while (!out_beat.last && cycles < len + 10);
        if (!out_beat.last) begin
            log_problem("playback did not end with a last beat in time");
        end
    endtask

    task automatic finish_test(string name);
        // let the checks on and after the final beat run
        repeat (2) @(negedge port0_clk);
        if (errors == errors_at_start) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ----------------------------------------
    // expected output from the back of the queue
    // ----------------------------------------

    always @(negedge port0_clk) begin
        exp_present = 1'b0;
        if (out_beat.valid && kept.size() > 0) begin
            exp_data    = kept[$];
            exp_last    = (kept.size() == 1);
            exp_present = 1'b1;
            void'(kept.pop_back());
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    a_reset_state: assert property (@(posedge port0_clk)
        $rose(rst_n) |-> !out_beat.valid && !out_beat.last && !busy && !overflow
    ) else log_problem("outputs not all low after reset");

    a_beat_expected: assert property (@(posedge port0_clk) disable iff (!rst_n)
        out_beat.valid |-> exp_present
    ) else log_problem("output beat with no stored word left to send");

    a_out_data: assert property (@(posedge port0_clk) disable iff (!rst_n)
        (out_beat.valid && exp_present) |-> out_beat.data == exp_data
    ) else log_mismatch("out_beat.data", $sampled(exp_data), $sampled(out_beat.data));

    a_out_last: assert property (@(posedge port0_clk) disable iff (!rst_n)
        (out_beat.valid && exp_present) |-> out_beat.last == exp_last
    ) else log_mismatch("out_beat.last", $sampled(exp_last), $sampled(out_beat.last));

    a_no_gap: assert property (@(posedge port0_clk) disable iff (!rst_n)
        (out_beat.valid && !out_beat.last) |=> out_beat.valid
    ) else log_mismatch("out_beat.valid", 1, $sampled(out_beat.valid));

    a_first_beat: assert property (@(posedge port0_clk) disable iff (!rst_n)
        $rose(busy) |=> out_beat.valid
    ) else log_mismatch("out_beat.valid", 1, $sampled(out_beat.valid));

    a_busy_rise: assert property (@(posedge port0_clk) disable iff (!rst_n)
        (in_beat.valid && in_beat.last && !busy) |=> busy
    ) else log_mismatch("busy", 1, $sampled(busy));

    a_busy_fall: assert property (@(posedge port0_clk) disable iff (!rst_n)
        out_beat.last |=> !busy
    ) else log_mismatch("busy", 0, $sampled(busy));

    a_overflow: assert property (@(posedge port0_clk) disable iff (!rst_n)
        overflow == $past(ovf_expect)
    ) else log_mismatch("overflow", $sampled($past(ovf_expect)), $sampled(overflow));

    // ----------------------------------------
    // watchdog
    // ----------------------------------------

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge port0_clk);
        $display("timeout: tests still running after %0d cycles", watch_cycles);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin
        int total;
        in_beat         = '0;
        rst_n           = 1'b0;
        ovf_expect      = 1'b0;
        exp_present     = 1'b0;
        exp_data        = '0;
        exp_last        = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        passed          = 0;
        failed          = 0;
        lcg_state       = 32'd59;
        watch_cycles    = 0;

        // 0..9 random, then fixed cases, 13..15 random again
        for (int i = 0; i < NUM_FRAMES; i++) begin
            frame_len[i] = int'((lcg_next() >> 8) % 64) + 1;
        end
        frame_len[10] = 1;
        frame_len[11] = 70;
        frame_len[12] = 20;
        total = JUNK_BEATS;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            total += frame_len[i];
        end
        watch_cycles = total * 3 + 200;

        repeat (4) @(posedge port0_clk);
        @(negedge port0_clk);
        rst_n = 1'b1;
        finish_test("reset state");

        for (int i = 0; i < 10; i++) begin
            send_frame(frame_len[i]);
            wait_playback(frame_len[i]);
        end
        finish_test("random frames");

        send_frame(frame_len[10]);
        wait_playback(frame_len[10]);
        finish_test("single word frame");

        send_frame(frame_len[11]);
        wait_playback(frame_len[11]);
        finish_test("overlong frame");

        send_frame(frame_len[12]);
        send_ignored(JUNK_BEATS);
        wait_playback(frame_len[12]);
        send_frame(frame_len[13]);
        wait_playback(frame_len[13]);
        finish_test("input while busy");

        // second frame starts right after out_last
        send_frame(frame_len[14]);
        wait_playback(frame_len[14]);
        send_frame(frame_len[15]);
        wait_playback(frame_len[15]);
        finish_test("back to back frames");

        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
